//--- sources.f
rtl/bch_pkg.sv
rtl/bch_syndrome.sv
rtl/bch_locator.sv
rtl/bch_chien.sv
rtl/bch_correct.sv
rtl/bch_decoder.sv
tests/tb_clock.sv
tests/bch_decoder_assertions.sv
tests/bch_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the BCH(15,7) decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	--top-module bch_decoder_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vbch_decoder_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with exit status $status"
	exit $status
fi
exit 0

//--- tests/bch_decoder_tb.sv
`timescale 1ns/100ps

module bch_decoder_tb;

	localparam logic [8:0] gen_poly = 9'h1D1;   // x^8 + x^7 + x^6 + x^4 + 1
	localparam int         timeout  = 40;       // cycles per wait

	logic                  clk;
	logic                  arst_n;
	logic                  in_valid;
	logic                  in_bit;
	logic                  out_valid;
	logic                  out_bit;
	logic                  out_flip;
	logic                  status_valid;
	bch_pkg::dec_status_t  status;

	logic [14:0]           exp_word_q [$];      // corrected frame, oldest first
	logic [14:0]           exp_flip_q [$];      // positions that must flip
	bch_pkg::dec_status_t  exp_stat_q [$];
	logic [14:0]           got_word;            // out_bit collected, position 14 at msb
	logic [14:0]           got_flip;
	int                    n_sent = 0;
	int                    n_checked = 0;
	logic [3:0]            alpha_tbl [15];      // alpha^i in polynomial basis

	tb_clock u_clock (.clk(clk));

	bch_decoder uut (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_bit       (in_bit),
		.out_valid    (out_valid),
		.out_bit      (out_bit),
		.out_flip     (out_flip),
		.status_valid (status_valid),
		.status       (status)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic fail_value(input string name, input logic [14:0] exp, input logic [14:0] got);
		fail_run($sformatf("CHECK FAILED %s expected 0x%0h got 0x%0h", name, exp, got));
	endtask

	function automatic void build_alpha_table();
		logic [3:0] a;
		a = 4'd1;
		for (int i = 0; i < 15; i++) begin
			alpha_tbl[i] = a;
			a = {a[2:0], 1'b0} ^ (a[3] ? 4'b0011 : 4'b0000); // times x, x^4 = x + 1
		end
	endfunction

	// c(x) = m(x) * g(x), carry-less
	function automatic logic [14:0] encode(input logic [6:0] msg);
		logic [14:0] cw;
		cw = '0;
		for (int i = 0; i < 7; i++)
			if (msg[i])
				cw = cw ^ ({6'd0, gen_poly} << i);
		return cw;
	endfunction

	// direct evaluation r(alpha) and r(alpha^3)
	function automatic bch_pkg::syndrome_t ref_syndromes(input logic [14:0] r);
		bch_pkg::syndrome_t s;
		s = '0;
		for (int i = 0; i < 15; i++)
			if (r[i]) begin
				s.s1 = s.s1 ^ alpha_tbl[i];
				s.s3 = s.s3 ^ alpha_tbl[(3 * i) % 15];
			end
		return s;
	endfunction

	function automatic logic [14:0] one_bit_error();
		return 15'(1) << $urandom_range(14, 0);
	endfunction

	function automatic logic [14:0] two_bit_error();
		int a;
		int b;
		a = $urandom_range(14, 0);
		b = (a + 1 + $urandom_range(13, 0)) % 15;  // never equal to a
		return (15'(1) << a) | (15'(1) << b);
	endfunction

	task automatic drive_inputs(input logic v, input logic b);
		@(posedge clk);
		#0.5;                                      // clear of the sampling edge
		in_valid = v;
		in_bit   = b;
	endtask

	task automatic send_frame(input logic [14:0] cw, input logic [14:0] err,
			input int max_gap, input logic expect_fail);
		logic [14:0]          rx;
		bch_pkg::dec_status_t st;
		rx = cw ^ err;
		if (expect_fail) begin
			exp_word_q.push_back(rx);                // passed through untouched
			exp_flip_q.push_back('0);
			st.corr_count = 2'd0;
			st.fail       = 1'b1;
		end else begin
			exp_word_q.push_back(cw);
			exp_flip_q.push_back(err);
			st.corr_count = 2'($countones(err));
			st.fail       = 1'b0;
		end
		exp_stat_q.push_back(st);
		n_sent++;
		for (int p = 14; p >= 0; p--) begin
			repeat ($urandom_range(max_gap, 0))
				drive_inputs(1'b0, 1'b0);             // gap inside the frame
			drive_inputs(1'b1, rx[p]);
		end
		repeat (3)
			drive_inputs(1'b0, 1'b0);               // minimum spacing to the next frame
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (n_checked < n_sent && cycles < timeout) begin
			@(posedge clk);
			cycles++;
		end
		if (n_checked < n_sent)
			fail_run("no output arrived from the decoder within the timeout");
	endtask

	task automatic check_result();
		logic [14:0]          ew;
		logic [14:0]          ef;
		bch_pkg::dec_status_t es;
		if (exp_stat_q.size() == 0) begin
			fail_run("status arrived for a frame that was never sent");
		end else begin
			ew = exp_word_q.pop_front();
			ef = exp_flip_q.pop_front();
			es = exp_stat_q.pop_front();
			assert (got_word == ew) else fail_value("out_bit", ew, got_word);
			assert (got_flip == ef) else fail_value("out_flip", ef, got_flip);
			assert (status.corr_count == es.corr_count)
				else fail_value("status.corr_count", 15'(es.corr_count), 15'(status.corr_count));
			assert (status.fail == es.fail)
				else fail_value("status.fail", 15'(es.fail), 15'(status.fail));
			n_checked++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!arst_n) begin
			got_word = '0;
			got_flip = '0;
		end else begin
			if (out_valid) begin
				assert (exp_word_q.size() > 0)
					else fail_run("output appeared with no frame outstanding");
				got_word = {got_word[13:0], out_bit};
				got_flip = {got_flip[13:0], out_flip};
			end
			if (status_valid)
				check_result();
		end
	end

	initial begin
		logic [14:0]        cw;
		logic [14:0]        err;
		bch_pkg::syndrome_t s;
		int                 tries;
		in_valid = 1'b0;
		in_bit   = 1'b0;
		arst_n   = 1'b0;
		void'($urandom(86514));
		build_alpha_table();
		repeat (3) @(posedge clk);
		#0.5;
		arst_n = 1'b1;

		for (int f = 0; f < 4; f++)                 // clean codewords
			send_frame(encode(7'($urandom())), '0, 0, 1'b0);
		wait_results();

		for (int f = 0; f < 6; f++)
			send_frame(encode(7'($urandom())), one_bit_error(), 0, 1'b0);
		wait_results();

		for (int f = 0; f < 6; f++)
			send_frame(encode(7'($urandom())), two_bit_error(), 0, 1'b0);
		wait_results();

		// patterns with S1 = 0 and S3 != 0 are beyond t
		for (int f = 0; f < 3; f++) begin
			cw    = encode(7'($urandom()));
			tries = 0;
			err   = '0;
			s     = ref_syndromes(cw);
			while (!(s.s1 == '0 && s.s3 != '0) && tries < 500) begin
				err = 15'($urandom());
				s   = ref_syndromes(cw ^ err);
				tries++;
			end
			if (!(s.s1 == '0 && s.s3 != '0))
				fail_run("no error pattern with S1 = 0 and S3 != 0 was found");
			send_frame(cw, err, 0, 1'b1);
		end
		wait_results();

		// two frames in flight, random gaps inside each frame
		for (int f = 0; f < 10; f++) begin
			case ($urandom_range(2, 0))
				0:       err = '0;
				1:       err = one_bit_error();
				default: err = two_bit_error();
			endcase
			send_frame(encode(7'($urandom())), err, 3, 1'b0);
		end
		wait_results();

		// reset with one frame on the output and the next half received
		send_frame(encode(7'($urandom())), '0, 0, 1'b0);
		cw = encode(7'($urandom()));
		for (int p = 14; p > 7; p--)
			drive_inputs(1'b1, cw[p]);
		@(posedge clk);
		#0.5;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		exp_word_q.delete();                        // frame on the output is cut off
		exp_flip_q.delete();
		exp_stat_q.delete();
		n_sent = n_checked;
		repeat (3) @(posedge clk);
		#0.5;
		arst_n = 1'b1;
		repeat (25)
			drive_inputs(1'b0, 1'b0);                 // any output here is flagged
		send_frame(cw, one_bit_error(), 0, 1'b0);
		wait_results();

		if (n_checked == n_sent && exp_stat_q.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			fail_run("frames were sent that never produced a result");
		end
	end

endmodule

//--- tests/bch_decoder_assertions.sv
`timescale 1ns/100ps

module bch_decoder_assertions (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  out_valid,
	input logic                  out_flip,
	input logic                  status_valid,
	input bch_pkg::dec_status_t  status
);

	// outputs come out of reset quiet
	a_reset_quiet: assert property (@(posedge clk)
		$rose(arst_n) |-> (!out_valid && !out_flip && !status_valid))
		else $error("decoder outputs active right after reset");

	a_status_after_frame: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(out_valid) |-> status_valid)                // one cycle after the last bit
		else $error("status_valid missing after the end of a frame");

	a_status_only_after_frame: assert property (@(posedge clk) disable iff (!arst_n)
		status_valid |-> ($past(out_valid) && !out_valid))
		else $error("status_valid without a frame ending just before it");

	a_flip_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		out_flip |-> out_valid)
		else $error("out_flip outside the output frame");

	// a failed frame never counts corrections
	a_fail_no_count: assert property (@(posedge clk) disable iff (!arst_n)
		(status_valid && status.fail) |-> (status.corr_count == 2'd0))
		else $error("status.fail set with a nonzero correction count");

endmodule

bind bch_decoder bch_decoder_assertions u_assertions (
	.clk          (clk),
	.arst_n       (arst_n),
	.out_valid    (out_valid),
	.out_flip     (out_flip),
	.status_valid (status_valid),
	.status       (status)
);

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	localparam realtime half_period = 2.0;   // 4 ns period

	initial
		clk = 1'b0;

	always #(half_period)
		clk = ~clk;

endmodule

//--- rtl/bch_decoder.sv
`timescale 1ns/100ps

module bch_decoder (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  logic                  in_bit,
	output logic                  out_valid,
	output logic                  out_bit,
	output logic                  out_flip,
	output logic                  status_valid,
	output bch_pkg::dec_status_t  status
);

	logic                        syn_done;
	bch_pkg::syndrome_t          syn;
	logic [bch_pkg::code_n-1:0]  frame;
	logic                        loc_valid;
	bch_pkg::locator_t           loc;
	logic                        hit_valid;
	logic                        hit;
	logic                        search_done;
	logic [1:0]                  root_count;

	bch_syndrome u_syndrome (                 // frame in, S1/S3 out
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_bit      (in_bit),
		.syn_done    (syn_done),
		.syn         (syn),
		.frame       (frame)
	);

	bch_locator u_locator (                   // sigma coefficients
		.clk         (clk),
		.arst_n      (arst_n),
		.syn_done    (syn_done),
		.syn         (syn),
		.loc_valid   (loc_valid),
		.loc         (loc)
	);

	bch_chien u_chien (                       // root search, position 14 first
		.clk         (clk),
		.arst_n      (arst_n),
		.loc_valid   (loc_valid),
		.loc         (loc),
		.hit_valid   (hit_valid),
		.hit         (hit),
		.search_done (search_done),
		.root_count  (root_count)
	);

	bch_correct u_correct (
		.clk          (clk),
		.arst_n       (arst_n),
		.syn_done     (syn_done),
		.frame        (frame),
		.loc          (loc),
		.hit_valid    (hit_valid),
		.hit          (hit),
		.search_done  (search_done),
		.root_count   (root_count),
		.out_valid    (out_valid),
		.out_bit      (out_bit),
		.out_flip     (out_flip),
		.status_valid (status_valid),
		.status       (status)
	);

endmodule

//--- rtl/bch_correct.sv
`timescale 1ns/100ps

module bch_correct (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        syn_done,
	input  logic [bch_pkg::code_n-1:0]  frame,
	input  bch_pkg::locator_t           loc,
	input  logic                        hit_valid,
	input  logic                        hit,
	input  logic                        search_done,
	input  logic [1:0]                  root_count,
	output logic                        out_valid,
	output logic                        out_bit,
	output logic                        out_flip,
	output logic                        status_valid,
	output bch_pkg::dec_status_t        status
);

	logic [bch_pkg::code_n-1:0]  out_sr;     // msb is the position being emitted
	logic                        fix_ok;     // locator is usable
	logic [1:0]                  exp_roots;  // roots the locator degree predicts
	logic                        fail_now;

	// previous frame has left by the time the next syn_done comes
	always_ff @(posedge clk) begin
		if (syn_done)
			out_sr <= frame;
		else if (hit_valid)
			out_sr <= {out_sr[bch_pkg::code_n-2:0], 1'b0};
	end

	assign fix_ok    = (loc.err_case != bch_pkg::CASE_FAIL);
	assign out_valid = hit_valid;
	assign out_flip  = hit_valid && hit && fix_ok;
	assign out_bit   = out_sr[bch_pkg::code_n-1] ^ out_flip;

	always_comb begin
		case (loc.err_case)
			bch_pkg::CASE_ONE: exp_roots = 2'd1;
			bch_pkg::CASE_TWO: exp_roots = 2'd2;
			default:           exp_roots = 2'd0;
		endcase
	end

	assign fail_now = !fix_ok || (root_count != exp_roots);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status_valid <= 1'b0;
			status       <= '0;
		end else begin
			status_valid <= search_done;        // one cycle after the last bit out
			if (search_done) begin
				status.fail       <= fail_now;
				status.corr_count <= fail_now ? 2'd0 : root_count;
			end
		end
	end

endmodule

//--- rtl/bch_chien.sv
`timescale 1ns/100ps

module bch_chien (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               loc_valid,
	input  bch_pkg::locator_t  loc,
	output logic               hit_valid,
	output logic               hit,
	output logic               search_done,
	output logic [1:0]         root_count
);

	bch_pkg::chien_state_e  state;
	logic [3:0]             pos;          // position under test, 14 down to 0
	logic [1:0]             hit_cnt;      // roots found before this cycle
	bch_pkg::gf_elem_t      coef [2];     // sigma1, sigma2
	bch_pkg::gf_elem_t      z    [2];     // sigma_j * x^j at the current position
	bch_pkg::gf_elem_t      sum;          // sigma(x) evaluated

	assign coef[0] = loc.sig1;
	assign coef[1] = loc.sig2;

	// x runs alpha^1 .. alpha^15 = alpha^-14 .. alpha^-0
	// term j is loaded as sigma_j * alpha^j and then scaled by alpha^j per step
	always_ff @(posedge clk) begin
		for (int j = 0; j < 2; j++) begin
			if (loc_valid)
				z[j] <= bch_pkg::gf_mul(coef[j], bch_pkg::gf_alpha_pow(j + 1));
			else if (hit_valid)
				z[j] <= bch_pkg::gf_mul(z[j], bch_pkg::gf_alpha_pow(j + 1));
		end
	end

	// constant term of sigma is 1, a root makes the whole sum zero
	assign sum = bch_pkg::gf_elem_t'(1) ^ z[0] ^ z[1];

	assign hit_valid   = (state == bch_pkg::CH_RUN);
	assign hit         = hit_valid && (sum == '0);
	assign search_done = hit_valid && (pos == 4'd0);

	// includes the current hit so it is complete on search_done
	always_comb begin
		if (hit && hit_cnt != 2'd3)
			root_count = hit_cnt + 2'd1;
		else
			root_count = hit_cnt;               // saturate at 3
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= bch_pkg::CH_IDLE;
			pos     <= '0;
			hit_cnt <= '0;
		end else if (loc_valid) begin
			state   <= bch_pkg::CH_RUN;        // first position next cycle
			pos     <= 4'(bch_pkg::code_n - 1);
			hit_cnt <= '0;
		end else if (state == bch_pkg::CH_RUN) begin
			pos     <= pos - 4'd1;
			hit_cnt <= root_count;
			if (pos == 4'd0)
				state <= bch_pkg::CH_IDLE;         // 15 positions done
		end
	end

endmodule

//--- rtl/bch_locator.sv
`timescale 1ns/100ps

module bch_locator (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                syn_done,
	input  bch_pkg::syndrome_t  syn,
	output logic                loc_valid,
	output bch_pkg::locator_t   loc
);

	bch_pkg::gf_elem_t  s1_sq;     // S1^2
	bch_pkg::gf_elem_t  s1_cu;     // S1^3
	bch_pkg::gf_elem_t  s3_div;    // S3 / S1
	bch_pkg::err_case_e cls;
	bch_pkg::locator_t  loc_next;

	always_comb begin
		s1_sq  = bch_pkg::gf_mul(syn.s1, syn.s1);
		s1_cu  = bch_pkg::gf_mul(s1_sq, syn.s1);
		s3_div = bch_pkg::gf_mul(syn.s3, bch_pkg::gf_inv(syn.s1));
	end

	// syndrome case decides the degree of sigma
	always_comb begin
		if (syn.s1 == '0 && syn.s3 == '0)
			cls = bch_pkg::CASE_NONE;
		else if (syn.s1 == '0)
			cls = bch_pkg::CASE_FAIL;               // S3 alone cannot come from <= 2 errors
		else if (syn.s3 == s1_cu)
			cls = bch_pkg::CASE_ONE;
		else
			cls = bch_pkg::CASE_TWO;
	end

	// sigma1 = S1, sigma2 = S1^2 + S3/S1
	always_comb begin
		loc_next.sig1     = syn.s1;
		loc_next.sig2     = (cls == bch_pkg::CASE_TWO) ? (s1_sq ^ s3_div) : '0;
		loc_next.err_case = cls;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			loc_valid <= 1'b0;
		else
			loc_valid <= syn_done;
	end

	// held until the next frame's syndromes arrive
	always_ff @(posedge clk) begin
		if (syn_done)
			loc <= loc_next;
	end

endmodule

//--- rtl/bch_syndrome.sv
`timescale 1ns/100ps

module bch_syndrome (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        in_valid,
	input  logic                        in_bit,
	output logic                        syn_done,
	output bch_pkg::syndrome_t          syn,
	output logic [bch_pkg::code_n-1:0]  frame
);

	bch_pkg::syndrome_t                acc;       // horner accumulators
	bch_pkg::syndrome_t                acc_next;
	logic [bch_pkg::code_n-2:0]        shreg;     // bits 14..1 of the frame so far
	logic [3:0]                        bit_cnt;   // bits seen in this frame
	logic                              last_bit;

	assign last_bit = in_valid && (bit_cnt == 4'(bch_pkg::code_n - 1));

	// S = S*alpha^k + r_i, highest position enters first
	always_comb begin
		acc_next.s1 = bch_pkg::gf_mul(acc.s1, bch_pkg::gf_alpha_pow(1))
			^ bch_pkg::gf_elem_t'(in_bit);
		acc_next.s3 = bch_pkg::gf_mul(acc.s3, bch_pkg::gf_alpha_pow(3))
			^ bch_pkg::gf_elem_t'(in_bit);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc      <= '0;
			bit_cnt  <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= last_bit;                // one cycle after the last bit
			if (last_bit) begin
				acc     <= '0;                     // ready for the next frame at once
				bit_cnt <= '0;
			end else if (in_valid) begin
				acc     <= acc_next;
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// holding registers stay put while the next frame accumulates
	always_ff @(posedge clk) begin
		if (in_valid)
			shreg <= {shreg[bch_pkg::code_n-3:0], in_bit};
		if (last_bit) begin
			syn   <= acc_next;
			frame <= {shreg, in_bit};            // frame[14] is position 14
		end
	end

endmodule

//--- rtl/bch_pkg.sv
package bch_pkg;

	localparam int gf_m   = 4;                 // GF(2^4) element width
	localparam int code_n = 15;                // bits per frame
	localparam int data_k = 7;                 // message bits per codeword
	localparam logic [gf_m-1:0] gf_poly = 4'b0011; // x^4 + x + 1, top term implied

	typedef logic [gf_m-1:0] gf_elem_t;        // polynomial basis, bit 0 = alpha^0

	typedef struct packed {
		gf_elem_t s1;                          // r(alpha)
		gf_elem_t s3;                          // r(alpha^3)
	} syndrome_t;

	typedef enum logic [1:0] {
		CASE_NONE,                             // S1 = S3 = 0
		CASE_ONE,                              // S3 = S1^3
		CASE_TWO,                              // generic two-error locator
		CASE_FAIL                              // S1 = 0, S3 != 0, beyond t
	} err_case_e;

	// sigma(x) = 1 + sig1*x + sig2*x^2
	typedef struct packed {
		gf_elem_t  sig1;
		gf_elem_t  sig2;
		err_case_e err_case;
	} locator_t;

	typedef struct packed {
		logic [1:0] corr_count;                // bits flipped in this frame
		logic       fail;                      // uncorrectable or root count mismatch
	} dec_status_t;

	typedef enum logic {
		CH_IDLE,
		CH_RUN
	} chien_state_e;

	// shift-and-add multiply, reduced by gf_poly after each shift
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = sh[gf_m-1] ? ({sh[gf_m-2:0], 1'b0} ^ gf_poly) : {sh[gf_m-2:0], 1'b0};
		end
		return acc;
	endfunction

	// a^-1 = a^14 in GF(16); zero maps to zero on its own
	function automatic gf_elem_t gf_inv(input gf_elem_t a);
		gf_elem_t p;
		p = a;
		for (int i = 1; i < code_n - 1; i++)
			p = gf_mul(p, a);
		return p;
	endfunction

	// alpha^e, e small and constant at every call site
	function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
		gf_elem_t p;
		p = gf_elem_t'(1);
		for (int i = 0; i < code_n; i++)
			if (i < e)
				p = gf_mul(p, gf_elem_t'(2)); // 4'b0010 is alpha
		return p;
	endfunction

endpackage
